// ==== compile.f ====
+incdir+design
design/mem_hier_pkg.sv
design/memory_fetch_stage.sv
design/l1_cache.sv
design/l2_cache.sv
design/response_stage.sv
design/mem_hier_top.sv
bench/tb_mem_hier.sv

// ==== Makefile ====
SOURCES := $(filter-out +%,$(shell cat compile.f)) design/mem_hier_defs.svh

.PHONY: run clean

run: obj_dir/Vtb_mem_hier
	./obj_dir/Vtb_mem_hier

obj_dir/Vtb_mem_hier: compile.f $(SOURCES)
	verilator --binary --assert --top-module tb_mem_hier -f compile.f -o Vtb_mem_hier

clean:
	rm -rf obj_dir

// ==== bench/tb_mem_hier.sv ====
// Self-checking testbench for mem_hier_top, runs directed cache cases then random traffic
`default_nettype none
`timescale 1ns/100ps

`include "mem_hier_defs.svh"

module tb_mem_hier;
  import mem_hier_pkg::*;

  localparam int CYCLE_LIMIT = 2000;  // About 417 requests plus reset and drain gaps
  localparam int RAND_COUNT  = 400;

  logic  clock;
  logic  reset;
  logic  i_read;
  logic  i_write;
  addr_t i_addr;
  word_t i_wdata;
  logic  o_valid;
  word_t o_rdata;
  logic  o_hit_l1;
  logic  o_hit_l2;

  word_t       ref_mem [`MEM_WORDS];  // Latest word per address, in issue order
  word_t       exp_word_q [$];        // Expected responses, oldest first
  logic        exp_l1_q [$];
  logic        exp_l2_q [$];
  logic        chk_flag_q [$];        // Flags checked only for directed requests
  logic [31:0] rng_state;
  int          cycle_count = 0;
  word_t       exp_word;              // Entry popped by the compare process
  logic        exp_l1;
  logic        exp_l2;
  logic        chk_flag;

  mem_hier_top u_dut (
    .clock(clock), .reset(reset),
    .i_read(i_read), .i_write(i_write), .i_addr(i_addr), .i_wdata(i_wdata),
    .o_valid(o_valid), .o_rdata(o_rdata), .o_hit_l1(o_hit_l1), .o_hit_l2(o_hit_l2)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;  // 10 ns period
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "%s", what);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // A write returns its own word, a read the last word written there
  function automatic word_t expected_word(input logic wr, input addr_t addr, input word_t data);
    if (wr)
      return data;
    else
      return ref_mem[addr];
  endfunction

  // Drives one request for one cycle, called on a falling edge
  task automatic issue_request(input logic wr, input addr_t addr, input word_t data,
                               input logic chk, input logic l1, input logic l2);
    exp_word_q.push_back(expected_word(wr, addr, data));
    exp_l1_q.push_back(l1);
    exp_l2_q.push_back(l2);
    chk_flag_q.push_back(chk);
    if (wr)
      ref_mem[addr] = data;
    i_read  = !wr;
    i_write = wr;
    i_addr  = addr;
    i_wdata = data;
    @(negedge clock);
    i_read  = 1'b0;  // Next call may raise it again at once
    i_write = 1'b0;
  endtask

  // Waits for outstanding responses, gives up after max_cycles
  task automatic wait_responses(input int max_cycles);
    int n;
    n = 0;
    do
    begin
      @(posedge clock);
      n++;
    end
    while (exp_word_q.size() != 0 && n < max_cycles);
    @(negedge clock);
  endtask

  task automatic require_drained();
    wait_responses(8);
    if (exp_word_q.size() != 0)
      stop_on_error($sformatf("%0d requests never got a response", exp_word_q.size()));
  endtask

  task automatic run_random(input int count);
    logic  wr;
    addr_t addr;
    word_t data;
    for (int i = 0; i < count; i++)
    begin
      rng_state = xorshift32(rng_state);
      wr   = rng_state[0];
      addr = rng_state[7:2];    // Covers all 64 addresses
      data = rng_state[31:16];
      issue_request(wr, addr, data, 1'b0, 1'b0, 1'b0);  // Back to back
    end
  endtask

  // Cycle limit guards against a hung run
  always @(posedge clock)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT)
      stop_on_error($sformatf("timeout, run still going after %0d cycles", CYCLE_LIMIT));
  end

  // Outputs settle after the rising edge, so compare on the falling one
  always @(negedge clock)
  begin
    if (!reset && o_valid)
    begin
      if (exp_word_q.size() == 0)
        stop_on_error("response arrived with no request outstanding");
      else
      begin
        exp_word = exp_word_q.pop_front();
        exp_l1   = exp_l1_q.pop_front();
        exp_l2   = exp_l2_q.pop_front();
        chk_flag = chk_flag_q.pop_front();
        check_word("o_rdata", o_rdata, exp_word);
        if (chk_flag)
        begin
          check_flag("o_hit_l1", o_hit_l1, exp_l1);
          check_flag("o_hit_l2", o_hit_l2, exp_l2);
        end
      end
    end
  end

  initial
  begin
    reset     = 1'b1;
    i_read    = 1'b0;
    i_write   = 1'b0;
    i_addr    = '0;
    i_wdata   = '0;
    rng_state = 32'hd4b4;
    for (int i = 0; i < `MEM_WORDS; i++)
      ref_mem[i] = '0;  // Memory reads 0 after reset
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    // Cold read misses everywhere
    issue_request(1'b0, 6'h3f, 16'h0000, 1'b1, 1'b0, 1'b0);
    require_drained();

    // Write then read next cycle, read hits L1
    issue_request(1'b1, 6'h04, 16'ha5a5, 1'b1, 1'b0, 1'b0);
    issue_request(1'b0, 6'h04, 16'h0000, 1'b1, 1'b1, 1'b0);
    require_drained();

    // Three writes to set 0 push A out of L1, A still sits in L2
    issue_request(1'b1, 6'h10, 16'hc0de, 1'b1, 1'b0, 1'b0);
    issue_request(1'b1, 6'h12, 16'h0b0b, 1'b1, 1'b0, 1'b0);
    issue_request(1'b1, 6'h14, 16'h0c0c, 1'b1, 1'b0, 1'b0);
    issue_request(1'b0, 6'h10, 16'h0000, 1'b1, 1'b0, 1'b1);
    require_drained();

    // Nine fresh writes evict 0x20 dirty from L2, then read it straight away
    for (int i = 0; i < 9; i++)
      issue_request(1'b1, addr_t'(32'h20 + i), word_t'(32'h4400 + i), 1'b1, 1'b0, 1'b0);
    issue_request(1'b0, 6'h20, 16'h0000, 1'b1, 1'b0, 1'b0);  // Write-back lands this edge
    require_drained();

    run_random(RAND_COUNT);
    wait_responses(8);
    if (exp_word_q.size() != 0)
      stop_on_error($sformatf("%0d requests never got a response", exp_word_q.size()));
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== design/mem_hier_top.sv ====
// Top of the two-level cache hierarchy, the DUT that the testbench drives with read and write strobes
`default_nettype none
`timescale 1ns/100ps

module mem_hier_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                i_read,
  input  logic                i_write,
  input  mem_hier_pkg::addr_t i_addr,
  input  mem_hier_pkg::word_t i_wdata,
  output logic                o_valid,   // Two edges after the request edge
  output mem_hier_pkg::word_t o_rdata,
  output logic                o_hit_l1,
  output logic                o_hit_l2
);
  import mem_hier_pkg::*;

  // Stage 1 outputs
  logic  s1_valid;
  logic  s1_write;
  addr_t s1_addr;
  word_t s1_wdata;
  word_t s1_mem_word;

  // Stage 2 lookups and fill
  logic  l1_hit;
  word_t l1_word;
  logic  l2_hit;
  word_t l2_word;
  word_t fill_word;

  // L2 victim into memory
  logic  wb_valid;
  addr_t wb_addr;
  word_t wb_data;

  memory_fetch_stage u_fetch (
    .clock(clock), .reset(reset),
    .i_read(i_read), .i_write(i_write), .i_addr(i_addr), .i_wdata(i_wdata),
    .i_wb_valid(wb_valid), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
    .o_valid(s1_valid), .o_write(s1_write), .o_addr(s1_addr),
    .o_wdata(s1_wdata), .o_mem_word(s1_mem_word)
  );

  l1_cache u_l1 (
    .clock(clock), .reset(reset),
    .i_valid(s1_valid), .i_write(s1_write), .i_addr(s1_addr), .i_wdata(s1_wdata),
    .i_fill_word(fill_word),
    .o_hit(l1_hit), .o_word(l1_word)
  );

  l2_cache u_l2 (
    .clock(clock), .reset(reset),
    .i_valid(s1_valid), .i_write(s1_write), .i_addr(s1_addr), .i_wdata(s1_wdata),
    .i_fill_word(fill_word), .i_l1_hit(l1_hit),
    .o_hit(l2_hit), .o_word(l2_word),
    .o_wb_valid(wb_valid), .o_wb_addr(wb_addr), .o_wb_data(wb_data)
  );

  response_stage u_resp (
    .clock(clock), .reset(reset),
    .i_valid(s1_valid), .i_write(s1_write), .i_wdata(s1_wdata), .i_mem_word(s1_mem_word),
    .i_l1_hit(l1_hit), .i_l1_word(l1_word), .i_l2_hit(l2_hit), .i_l2_word(l2_word),
    .o_fill_word(fill_word),
    .o_valid(o_valid), .o_rdata(o_rdata), .o_hit_l1(o_hit_l1), .o_hit_l2(o_hit_l2)
  );

endmodule

`default_nettype wire

// ==== design/response_stage.sv ====
// Stage 2 word selection for cache fills and the registered response seen at the top level
`default_nettype none
`timescale 1ns/100ps

module response_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                i_valid,
  input  logic                i_write,
  input  mem_hier_pkg::word_t i_wdata,
  input  mem_hier_pkg::word_t i_mem_word,   // From the backing memory read
  input  logic                i_l1_hit,
  input  mem_hier_pkg::word_t i_l1_word,
  input  logic                i_l2_hit,
  input  mem_hier_pkg::word_t i_l2_word,
  output mem_hier_pkg::word_t o_fill_word,  // Allocation word for both caches
  output logic                o_valid,
  output mem_hier_pkg::word_t o_rdata,
  output logic                o_hit_l1,
  output logic                o_hit_l2
);
  import mem_hier_pkg::*;

  word_t resp_word;

  // Write data, else L2 copy, else memory
  assign o_fill_word = i_write ? i_wdata : (i_l2_hit ? i_l2_word : i_mem_word);

  // Writes return the new word even when L1 holds the old one
  assign resp_word = (i_l1_hit && !i_write) ? i_l1_word : o_fill_word;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      o_valid  <= 1'b0;
      o_hit_l1 <= 1'b0;
      o_hit_l2 <= 1'b0;
    end
    else
    begin
      o_valid  <= i_valid;                         // One pulse per request
      o_hit_l1 <= i_valid && i_l1_hit;
      o_hit_l2 <= i_valid && !i_l1_hit && i_l2_hit;  // L2 hit counts only after an L1 miss
    end
  end

  always_ff @(posedge clock)
  begin
    if (i_valid)
      o_rdata <= resp_word;
  end

endmodule

`default_nettype wire

// ==== design/l2_cache.sv ====
// Eight-line fully associative write-back L2 used in stage 2, with true LRU ages and victim output
`default_nettype none
`timescale 1ns/100ps

`include "mem_hier_defs.svh"

module l2_cache (
  input  logic                clock,
  input  logic                reset,
  input  logic                i_valid,      // Stage 2 holds a request
  input  logic                i_write,
  input  mem_hier_pkg::addr_t i_addr,
  input  mem_hier_pkg::word_t i_wdata,
  input  mem_hier_pkg::word_t i_fill_word,  // Word to allocate on a miss
  input  logic                i_l1_hit,     // L1 already served a read
  output logic                o_hit,
  output mem_hier_pkg::word_t o_word,
  output logic                o_wb_valid,   // Dirty victim leaves this cycle
  output mem_hier_pkg::addr_t o_wb_addr,
  output mem_hier_pkg::word_t o_wb_data
);
  import mem_hier_pkg::*;

  word_t   data_q  [`L2_LINES];
  addr_t   tag_q   [`L2_LINES];   // Full address as tag
  logic    valid_q [`L2_LINES];
  logic    dirty_q [`L2_LINES];
  l2_age_t age_q   [`L2_LINES];

  logic     act;          // Writes and L1 read misses reach L2
  l2_slot_t hit_slot;
  l2_slot_t victim_slot;
  l2_slot_t use_slot;
  l2_age_t  old_age;      // Age before the touch
  logic     free_found;
  logic     dup_tag;      // Two valid lines with one address

  assign act = i_valid && (i_write || !i_l1_hit);

  // Associative compare across all lines
  always_comb
  begin
    o_hit    = 1'b0;
    hit_slot = '0;
    for (int i = 0; i < `L2_LINES; i++)
    begin
      if (valid_q[i] && (tag_q[i] == i_addr))
      begin
        o_hit    = 1'b1;
        hit_slot = l2_slot_t'(i);
      end
    end
  end

  // First empty line, else the line with the oldest age
  always_comb
  begin
    free_found  = 1'b0;
    victim_slot = '0;
    for (int i = 0; i < `L2_LINES; i++)
    begin
      if (!valid_q[i] && !free_found)
      begin
        victim_slot = l2_slot_t'(i);
        free_found  = 1'b1;
      end
    end
    if (!free_found)
    begin
      for (int i = 0; i < `L2_LINES; i++)
        if (age_q[i] == l2_age_t'(`L2_LINES-1))
          victim_slot = l2_slot_t'(i);
    end
  end

  assign use_slot = o_hit ? hit_slot : victim_slot;
  assign old_age  = o_hit ? age_q[hit_slot] : l2_age_t'(`L2_LINES-1);  // Fill acts as oldest
  assign o_word   = data_q[hit_slot];

  // Victim goes to memory in the cycle it is replaced
  assign o_wb_valid = act && !o_hit && valid_q[victim_slot] && dirty_q[victim_slot];
  assign o_wb_addr  = tag_q[victim_slot];
  assign o_wb_data  = data_q[victim_slot];

  // Valid, dirty and ages
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `L2_LINES; i++)
      begin
        valid_q[i] <= 1'b0;
        dirty_q[i] <= 1'b0;
        age_q[i]   <= '0;
      end
    end
    else if (act)
    begin
      for (int i = 0; i < `L2_LINES; i++)
      begin
        if (l2_slot_t'(i) == use_slot)
          age_q[i] <= '0;                 // Touched line is newest
        else if (valid_q[i] && (age_q[i] < old_age))
          age_q[i] <= age_q[i] + 1'b1;    // Younger lines step back one place
      end
      valid_q[use_slot] <= 1'b1;
      if (!o_hit)
        dirty_q[use_slot] <= i_write;     // Read fill is clean
      else if (i_write)
        dirty_q[use_slot] <= 1'b1;
    end
  end

  // Tags and data
  always_ff @(posedge clock)
  begin
    if (act)
    begin
      if (!o_hit)
      begin
        tag_q[use_slot]  <= i_addr;
        data_q[use_slot] <= i_fill_word;
      end
      else if (i_write)
      begin
        data_q[use_slot] <= i_wdata;
      end
    end
  end

  always_comb
  begin
    dup_tag = 1'b0;
    for (int i = 0; i < `L2_LINES; i++)
      for (int j = i + 1; j < `L2_LINES; j++)
        if (valid_q[i] && valid_q[j] && (tag_q[i] == tag_q[j]))
          dup_tag = 1'b1;
  end

  a_unique_tags: assert property (@(posedge clock) disable iff (reset) !dup_tag)
    else $error("two valid L2 lines hold the same address");

  // Only a miss replaces a line, so the victim is never the requested address
  a_wb_on_miss: assert property (@(posedge clock) disable iff (reset)
    o_wb_valid |-> (o_wb_addr != i_addr))
    else $error("L2 write-back of the line being requested");

endmodule

`default_nettype wire

// ==== design/l1_cache.sv ====
// Two-set two-way L1 used in stage 2, combinational lookup and commit on the next edge
`default_nettype none
`timescale 1ns/100ps

`include "mem_hier_defs.svh"

module l1_cache (
  input  logic                clock,
  input  logic                reset,
  input  logic                i_valid,      // Stage 2 holds a request
  input  logic                i_write,
  input  mem_hier_pkg::addr_t i_addr,
  input  mem_hier_pkg::word_t i_wdata,
  input  mem_hier_pkg::word_t i_fill_word,  // Word to allocate on a miss
  output logic                o_hit,
  output mem_hier_pkg::word_t o_word        // Hit way data
);
  import mem_hier_pkg::*;

  word_t   data_q  [`L1_SETS][`L1_WAYS];
  l1_tag_t tag_q   [`L1_SETS][`L1_WAYS];
  logic    valid_q [`L1_SETS][`L1_WAYS];
  l1_way_t lru_q   [`L1_SETS];              // Way to replace next

  logic                set_sel;             // Address bit 0
  l1_tag_t             tag_in;
  logic [`L1_WAYS-1:0] way_hit;
  l1_way_t             hit_way;
  l1_way_t             victim_way;
  l1_way_t             use_way;             // Way touched by the commit

  assign set_sel = i_addr[0];
  assign tag_in  = i_addr[`ADDR_W-1:1];

  // Tag compare on both ways of the set
  always_comb
  begin
    for (int w = 0; w < `L1_WAYS; w++)
      way_hit[w] = valid_q[set_sel][w] && (tag_q[set_sel][w] == tag_in);
  end

  assign o_hit   = |way_hit;
  assign hit_way = l1_way_t'(way_hit[1]);   // Way 1 else way 0
  assign o_word  = data_q[set_sel][hit_way];

  // Empty way 0 first, then empty way 1, then the LRU way
  always_comb
  begin
    if (!valid_q[set_sel][0])
      victim_way = 1'b0;
    else if (!valid_q[set_sel][1])
      victim_way = 1'b1;
    else
      victim_way = lru_q[set_sel];
  end

  assign use_way = o_hit ? hit_way : victim_way;

  // Valid bits and LRU pointer
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < `L1_SETS; s++)
      begin
        lru_q[s] <= '0;
        for (int w = 0; w < `L1_WAYS; w++)
          valid_q[s][w] <= 1'b0;
      end
    end
    else if (i_valid)
    begin
      valid_q[set_sel][use_way] <= 1'b1;
      lru_q[set_sel]            <= ~use_way;  // Other way becomes LRU
    end
  end

  // Tags and data
  always_ff @(posedge clock)
  begin
    if (i_valid)
    begin
      if (!o_hit)
      begin
        data_q[set_sel][use_way] <= i_fill_word;  // Allocate on read and write misses
        tag_q[set_sel][use_way]  <= tag_in;
      end
      else if (i_write)
      begin
        data_q[set_sel][use_way] <= i_wdata;      // Write hit updates in place
      end
    end
  end

  // Fill only ever targets a missing tag, so one tag lives in one way
  a_single_way_hit: assert property (@(posedge clock) disable iff (reset)
    i_valid |-> !(&way_hit))
    else $error("L1 tag present in both ways of a set");

endmodule

`default_nettype wire

// ==== design/memory_fetch_stage.sv ====
// Pipeline stage 1 that captures each request and reads the backing memory for the cache stage
`default_nettype none
`timescale 1ns/100ps

`include "mem_hier_defs.svh"

module memory_fetch_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                i_read,      // Read strobe, one cycle per request
  input  logic                i_write,     // Write strobe
  input  mem_hier_pkg::addr_t i_addr,
  input  mem_hier_pkg::word_t i_wdata,
  input  logic                i_wb_valid,  // Dirty victim from L2
  input  mem_hier_pkg::addr_t i_wb_addr,
  input  mem_hier_pkg::word_t i_wb_data,
  output logic                o_valid,     // Request sits in stage 2
  output logic                o_write,
  output mem_hier_pkg::addr_t o_addr,
  output mem_hier_pkg::word_t o_wdata,
  output mem_hier_pkg::word_t o_mem_word   // Backing word at o_addr
);
  import mem_hier_pkg::*;

  word_t mem_q [`MEM_WORDS];  // Backing memory
  logic  req;                 // Any strobe this cycle
  logic  wb_fwd;              // Write-back lands on the address being read

  assign req    = i_read | i_write;
  assign wb_fwd = i_wb_valid && (i_wb_addr == i_addr);

  // Backing array, only L2 victims write it
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MEM_WORDS; i++)
        mem_q[i] <= '0;  // Memory reads 0 after reset
    end
    else if (i_wb_valid)
    begin
      mem_q[i_wb_addr] <= i_wb_data;
    end
  end

  // Request control bits
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      o_valid <= 1'b0;
      o_write <= 1'b0;
    end
    else
    begin
      o_valid <= req;
      o_write <= i_write;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge clock)
  begin
    if (req)
    begin
      o_addr  <= i_addr;
      o_wdata <= i_wdata;
      // A victim written back on this same edge wins over the stored word
      o_mem_word <= wb_fwd ? i_wb_data : mem_q[i_addr];
    end
  end

  // Requests are either a read or a write, never both
  a_one_strobe: assert property (@(posedge clock) disable iff (reset)
    !(i_read && i_write))
    else $error("read and write strobes high together");

endmodule

`default_nettype wire

// ==== design/mem_hier_pkg.sv ====
// Vector types shared by the cache hierarchy RTL and its testbench, imported by each user
`default_nettype none

`include "mem_hier_defs.svh"

package mem_hier_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;  // Word address, also the full L2 tag
  typedef logic [`WORD_W-1:0] word_t;  // Data word

  // L1 tag drops the set bit
  typedef logic [`ADDR_W-$clog2(`L1_SETS)-1:0] l1_tag_t;
  typedef logic [$clog2(`L1_WAYS)-1:0]         l1_way_t;  // Way number inside a set

  typedef logic [$clog2(`L2_LINES)-1:0] l2_slot_t;  // L2 line number
  typedef logic [$clog2(`L2_LINES)-1:0] l2_age_t;   // 0 is most recent, max is LRU

endpackage

`default_nettype wire

// ==== design/mem_hier_defs.svh ====
// Width and geometry macros for the cache hierarchy, pulled in by the package and the RTL files
`ifndef MEM_HIER_DEFS_SVH
`define MEM_HIER_DEFS_SVH

// Datapath widths
`define ADDR_W    6   // Word address bits
`define WORD_W    16  // Bits per data word

// L1 geometry, set index is address bit 0
`define L1_SETS   2
`define L1_WAYS   2

// L2 geometry, fully associative
`define L2_LINES  8

// Backing memory depth, one word per address
`define MEM_WORDS 64

`endif
